// ==== project.f ====
+incdir+logic
logic/armCtrlPkg.sv
logic/aluDecoder.sv
logic/condUnit.sv
logic/mainDecoder.sv
logic/controller.sv
verif/controller_properties.sv
verif/controllerTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f project.f \
  --top-module controllerTb \
  -o controllerSim

./obj_dir/controllerSim

// ==== verif/controllerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "armCtrl_cfg.svh"

module controllerTb import armCtrlPkg::*; ();

  localparam int RESET_CYCLES   = 4;
  localparam int NUM_CYCLES     = 2000;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_CYCLES + 496;  // 2,500 cycles
  localparam logic [31:0] SEED  = 32'hc9fd_bce4;

  logic        clk;
  logic        reset;
  instrWordT   instrD;
  flagsT       flagsE;
  logic [31:0] aluResultE;
  logic        stallE;
  logic        flushE;
  logic        stallM;
  logic        stallW;
  logic        flushW;
  logic [1:0]  regSrcD;
  logic [1:0]  immSrcD;
  logic        aluSrcE;
  logic [3:0]  aluControlE;
  logic [2:0]  multControlE;
  logic        memToRegE;
  logic        branchTakenE;
  aluSteerT    aluSteerE;
  flagsT       previousFlagsE;
  logic        multEnable;
  logic        writeByteE;
  memCtrlT     memCtrlM;
  wbCtrlT      wbCtrlW;
  logic        pcWrPendingF;

  // Model state, one entry per stage register
  decodeCtrlT mE;
  instrWordT  mInstrE;
  flagsT      mFlags;
  memCtrlT    mM;
  wbCtrlT     mW;
  int         cycleCount = 0;

  controller u_dut (.*);

  bind controller controllerProperties u_props (
    .clk          (clk),
    .reset        (reset),
    .flushE       (flushE),
    .branchTakenE (branchTakenE),
    .condExE      (condExE),
    .ctrlE        (ctrlE),
    .memCtrlM     (memCtrlM)
  );

  always #50 clk = ~clk;  // 100 ns period

  // ========================================
  // Reference tables
  // ========================================
  function automatic decodeCtrlT decodeInstr(instrWordT i);
    decodeCtrlT c;
    logic [1:0] cls;
    c = '0;
    cls = i.dpView.instrClass;
    c.cond = i.dpView.cond;
    c.multControl = i.dpView.opcode[2:0];
    c.aluControl = `OP_ADD;                  // Branch and unused classes add
    if (cls == `CLASS_DP) begin
      c.regWrite = 1'b1;
      c.aluOp = 1'b1;
      c.aluSrc = i.dpView.immFlag;
      c.multSelect = !i.dpView.immFlag && (i.dpView.rest[7:4] == 4'b1001);
      c.aluControl = i.dpView.opcode;
      c.flagWrite = {i.dpView.setFlags, i.dpView.setFlags};
    end else if (cls == `CLASS_MEM) begin
      c.memAluOp = 1'b1;
      c.aluSrc = !i.memView.regOffset;       // Immediate offset
      c.memToReg = i.memView.load;
      c.regWrite = i.memView.load;
      c.memWrite = !i.memView.load;
      c.aluControl = i.memView.up ? `OP_ADD_MEM : `OP_SUB_MEM;
    end else if (cls == `CLASS_BR) begin
      c.aluSrc = 1'b1;
      c.branch = 1'b1;
    end
    c.pcSrc = c.branch || (c.regWrite && (i.dpView.rd == 4'd15));  // R15 target
    return c;
  endfunction

  function automatic logic condPasses(logic [3:0] cond, flagsT f);
    case (cond)
      `COND_EQ: return f.z;
      `COND_NE: return !f.z;
      `COND_CS: return f.c;
      `COND_CC: return !f.c;
      `COND_MI: return f.n;
      `COND_PL: return !f.n;
      `COND_VS: return f.v;
      `COND_VC: return !f.v;
      `COND_HI: return f.c && !f.z;
      `COND_LS: return !f.c || f.z;
      `COND_GE: return f.n == f.v;
      `COND_LT: return f.n != f.v;
      `COND_GT: return !f.z && (f.n == f.v);
      `COND_LE: return f.z || (f.n != f.v);
      `COND_AL: return 1'b1;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic aluSteerT steerExpect(logic active, logic [3:0] op, logic carry);
    aluSteerT s;
    s = '0;
    if (active) begin
      case (op)
        `OP_AND, `OP_TST, `OP_BIC: s.operation = `ALU_AND;
        `OP_EOR, `OP_TEQ:          s.operation = `ALU_XOR;
        `OP_ORR:                   s.operation = `ALU_OR;
        `OP_MOV, `OP_MVN:          s.operation = `ALU_PASS;
        default:                   s.operation = `ALU_ADD;
      endcase
      if (op inside {`OP_SUB, `OP_RSB, `OP_ADD, `OP_ADC, `OP_SBC, `OP_RSC, `OP_CMP, `OP_CMN})
        s.cvUpdate = `CV_ARITH;
      else
        s.cvUpdate = `CV_LOGIC;
      s.invertB = op inside {`OP_SUB, `OP_SBC, `OP_CMP, `OP_BIC, `OP_MVN};
      s.reverseInputs = op inside {`OP_RSB, `OP_RSC};
      if (op inside {`OP_SUB, `OP_RSB, `OP_CMP})
        s.carryIn = 1'b1;
      else if (op inside {`OP_ADC, `OP_SBC, `OP_RSC})
        s.carryIn = carry;                   // Stored C flag
      s.noRegWrite = op inside {`OP_TST, `OP_TEQ, `OP_CMP, `OP_CMN};
    end
    return s;
  endfunction

  // Gated Execute controls headed for Memory
  function automatic memCtrlT memStageExpect(decodeCtrlT c, instrWordT i, flagsT f,
                                             logic [31:0] res);
    memCtrlT  m;
    aluSteerT s;
    logic     condOk;
    logic     byteAcc;
    condOk = condPasses(c.cond, f);
    s = steerExpect(c.aluOp || c.memAluOp, c.aluControl, f.c);
    byteAcc = (i.memView.instrClass == `CLASS_MEM) && i.memView.byteAccess;
    m.memWrite = c.memWrite && condOk;
    m.memToReg = c.memToReg;
    m.regWrite = c.regWrite && condOk && !s.noRegWrite;
    m.pcSrc = c.pcSrc && condOk;
    m.loadByte = byteAcc;
    m.byteOffset = res[1:0];
    if (!byteAcc)
      m.byteMask = 4'b1111;                  // Word access, all lanes
    else begin
      case (res[1:0])
        2'd0:    m.byteMask = 4'b0001;
        2'd1:    m.byteMask = 4'b0010;
        2'd2:    m.byteMask = 4'b0100;
        default: m.byteMask = 4'b1000;
      endcase
    end
    return m;
  endfunction

  // ========================================
  // Model step, checks, stimulus
  // ========================================
  // Called right after a rising edge, sees the inputs the DUT just sampled
  task automatic stepModel();
    memCtrlT mNext;
    flagsT   fNext;
    logic    condOk;
    if (reset) begin
      mE = '0;
      mInstrE = '0;
      mFlags = '0;
      mM = '0;
      mW = '0;
    end else begin
      condOk = condPasses(mE.cond, mFlags);
      mNext = memStageExpect(mE, mInstrE, mFlags, aluResultE);
      fNext = mFlags;
      if (mE.flagWrite[1] && condOk) begin   // N and Z pair
        fNext.n = flagsE.n;
        fNext.z = flagsE.z;
      end
      if (mE.flagWrite[0] && condOk) begin   // C and V pair
        fNext.c = flagsE.c;
        fNext.v = flagsE.v;
      end
      if (flushW)
        mW = '0;
      else if (!stallW) begin
        mW.memToReg = mM.memToReg;
        mW.regWrite = mM.regWrite;
        mW.pcSrc = mM.pcSrc;
        mW.loadByte = mM.loadByte;
        mW.byteOffset = mM.byteOffset;
      end
      if (!stallM)
        mM = mNext;
      if (!stallE)
        mFlags = fNext;
      if (flushE) begin                      // Flush beats stall
        mE = '0;
        mInstrE = '0;
      end else if (!stallE) begin
        mE = decodeInstr(instrD);
        mInstrE = instrD;
      end
    end
  endtask

  task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  task automatic checkOutputs();
    decodeCtrlT dD;
    logic       condOk;
    logic       memE;
    logic [1:0] expRegSrc;
    logic [1:0] expImmSrc;
    dD = decodeInstr(instrD);
    condOk = condPasses(mE.cond, mFlags);
    memE = (mInstrE.memView.instrClass == `CLASS_MEM);
    expRegSrc = 2'b00;
    expImmSrc = 2'b00;
    if (instrD.memView.instrClass == `CLASS_MEM) begin
      expRegSrc = instrD.memView.load ? 2'b00 : 2'b10;       // Store reads Rd
      expImmSrc = instrD.memView.regOffset ? 2'b00 : 2'b01;
    end else if (instrD.memView.instrClass == `CLASS_BR) begin
      expRegSrc = 2'b01;
      expImmSrc = 2'b10;
    end
    checkEq(64'(regSrcD), 64'(expRegSrc), "regSrcD");
    checkEq(64'(immSrcD), 64'(expImmSrc), "immSrcD");
    checkEq(64'(aluSrcE), 64'(mE.aluSrc), "aluSrcE");
    checkEq(64'(aluControlE), 64'(mE.aluControl), "aluControlE");
    checkEq(64'(multControlE), 64'(mE.multControl), "multControlE");
    checkEq(64'(memToRegE), 64'(mE.memToReg), "memToRegE");
    checkEq(64'(branchTakenE), 64'(mE.branch && condOk), "branchTakenE");
    checkEq(64'(aluSteerE),
            64'(steerExpect(mE.aluOp || mE.memAluOp, mE.aluControl, mFlags.c)), "aluSteerE");
    checkEq(64'(previousFlagsE), 64'(mFlags), "previousFlagsE");
    checkEq(64'(multEnable), 64'((mInstrE.dpView.instrClass == `CLASS_DP) &&
            !mInstrE.dpView.immFlag && (mInstrE.dpView.rest[7:4] == 4'b1001)), "multEnable");
    checkEq(64'(writeByteE), 64'(memE && mInstrE.memView.byteAccess &&
            !mInstrE.memView.load), "writeByteE");
    checkEq(64'(memCtrlM), 64'(mM), "memCtrlM");
    checkEq(64'(wbCtrlW), 64'(mW), "wbCtrlW");
    checkEq(64'(pcWrPendingF), 64'(dD.pcSrc || mE.pcSrc || mM.pcSrc), "pcWrPendingF");
  endtask

  task automatic driveRandom();
    instrWordT  w;
    logic [1:0] cls;
    w = $urandom;
    cls = 2'($urandom_range(0, 2));          // DP, MEM or BR
    w.dpView.instrClass = cls;
    w.dpView.cond = 4'($urandom_range(0, 14));
    if ((cls == `CLASS_DP) && ($urandom_range(0, 3) == 0)) begin
      w.dpView.immFlag = 1'b0;               // Force a multiply
      w.dpView.rest[7:4] = 4'b1001;
    end
    instrD <= w;
    flagsE <= 4'($urandom);
    aluResultE <= $urandom;
    stallE <= ($urandom_range(0, 7) == 0);
    stallM <= ($urandom_range(0, 7) == 0);
    stallW <= ($urandom_range(0, 7) == 0);
    flushE <= ($urandom_range(0, 31) == 0);  // Flushes kept rare
    flushW <= ($urandom_range(0, 31) == 0);
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $fatal(1, "timeout");
    end
  end

  initial begin
    void'($urandom(SEED));
    clk = 1'b0;
    reset = 1'b1;
    instrD = '0;
    flagsE = '0;
    aluResultE = '0;
    stallE = 1'b0;
    flushE = 1'b0;
    stallM = 1'b0;
    stallW = 1'b0;
    flushW = 1'b0;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      stepModel();
    end
    reset <= 1'b0;
    @(negedge clk);
    checkEq(64'({regSrcD, immSrcD, aluSrcE, aluControlE, multControlE, memToRegE,
                 branchTakenE, aluSteerE, previousFlagsE, multEnable, writeByteE,
                 memCtrlM, wbCtrlW, pcWrPendingF}), 64'd0, "outputs after reset");
    checkOutputs();
    for (int n = 0; n < NUM_CYCLES; n++) begin
      @(posedge clk);
      stepModel();
      driveRandom();
      @(negedge clk);                        // Outputs settled mid-cycle
      checkOutputs();
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/controller_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module controllerProperties import armCtrlPkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       flushE,
  input logic       branchTakenE,
  input logic       condExE,
  input decodeCtrlT ctrlE,
  input memCtrlT    memCtrlM
);

  // ========================================
  // Reset and flush
  // ========================================
  // No store leaves a reset cycle
  memWriteAfterReset: assert property (
    @(posedge clk) reset |=> !memCtrlM.memWrite
  ) else $error("memCtrlM.memWrite high after reset");

  flushClearsExecute: assert property (
    @(posedge clk) flushE |=> (ctrlE == '0)    // Bubble in Execute
  ) else $error("Execute controls not cleared after flushE");

  // ========================================
  // Conditional execution
  // ========================================
  // A taken branch also carries the decoded PC write
  branchNeedsCond: assert property (
    @(posedge clk) branchTakenE |-> (condExE && ctrlE.pcSrc)
  ) else $error("branchTakenE without a passing condition or PC write");

endmodule

`default_nettype wire

// ==== logic/controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "armCtrl_cfg.svh"

module controller import armCtrlPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  instrWordT   instrD,
  input  flagsT       flagsE,        // ALU flags of Execute instruction
  input  logic [31:0] aluResultE,
  input  logic        stallE,
  input  logic        flushE,
  input  logic        stallM,
  input  logic        stallW,
  input  logic        flushW,
  // Decode
  output logic [1:0]  regSrcD,
  output logic [1:0]  immSrcD,
  // Execute
  output logic        aluSrcE,
  output logic [3:0]  aluControlE,
  output logic [2:0]  multControlE,
  output logic        memToRegE,
  output logic        branchTakenE,
  output aluSteerT    aluSteerE,
  output flagsT       previousFlagsE,
  output logic        multEnable,
  output logic        writeByteE,
  // Memory, Writeback, Fetch
  output memCtrlT     memCtrlM,
  output wbCtrlT      wbCtrlW,
  output logic        pcWrPendingF
);

  decodeCtrlT ctrlD;
  decodeCtrlT ctrlE;
  instrWordT  instrE;      // Instruction follows its controls into Execute
  logic       condExE;
  logic       isMemE;
  logic       byteAccessE;
  memCtrlT    memCtrlE;
  wbCtrlT     wbCtrlM;

  // ======================================
  // Decode
  // ======================================
  mainDecoder u_mainDecoder (
    .instr (instrD),
    .ctrl  (ctrlD)
  );

  // Register-file read port and immediate extension select
  always_comb begin
    regSrcD = 2'b00;
    immSrcD = 2'b00;       // DP rotated immediate
    case (instrD.dpView.instrClass)
      `CLASS_MEM: begin
        if (!instrD.memView.load)
          regSrcD = 2'b10;   // Store reads Rd as data
        if (!instrD.memView.regOffset)
          immSrcD = 2'b01;   // 12-bit offset
      end
      `CLASS_BR: begin
        regSrcD = 2'b01;     // PC as base
        immSrcD = 2'b10;     // 24-bit branch offset
      end
      default: begin
        regSrcD = 2'b00;
        immSrcD = 2'b00;
      end
    endcase
  end

  // ======================================
  // Execute
  // ======================================
  // Flush wins over stall
  always_ff @(posedge clk) begin
    if (reset || flushE) begin
      ctrlE  <= '0;
      instrE <= '0;
    end else if (!stallE) begin
      ctrlE  <= ctrlD;
      instrE <= instrD;
    end
  end

  // Memory ops steer the ALU too, for address add/subtract
  aluDecoder u_aluDecoder (
    .aluOp      (ctrlE.aluOp | ctrlE.memAluOp),
    .aluControl (ctrlE.aluControl),
    .carry      (previousFlagsE.c),
    .steer      (aluSteerE)
  );

  condUnit u_condUnit (
    .clk       (clk),
    .reset     (reset),
    .stallE    (stallE),
    .cond      (ctrlE.cond),
    .flagWrite (ctrlE.flagWrite),
    .aluFlags  (flagsE),
    .condEx    (condExE),
    .flags     (previousFlagsE)
  );

  assign aluSrcE      = ctrlE.aluSrc;
  assign aluControlE  = ctrlE.aluControl;
  assign multControlE = ctrlE.multControl;
  assign memToRegE    = ctrlE.memToReg;
  assign branchTakenE = ctrlE.branch & condExE;

  assign isMemE      = (instrE.memView.instrClass == `CLASS_MEM);
  assign byteAccessE = isMemE & instrE.memView.byteAccess;    // LDRB/STRB
  assign writeByteE  = byteAccessE & ~instrE.memView.load;
  assign multEnable  = ctrlE.multSelect;                      // MUL/MLA in Execute

  // Write controls only survive a passing condition
  always_comb begin
    memCtrlE.memWrite   = ctrlE.memWrite & condExE;
    memCtrlE.memToReg   = ctrlE.memToReg;
    memCtrlE.regWrite   = ctrlE.regWrite & condExE & ~aluSteerE.noRegWrite;
    memCtrlE.pcSrc      = ctrlE.pcSrc & condExE;
    memCtrlE.byteMask   = byteAccessE ? (4'b0001 << aluResultE[1:0]) : 4'b1111;
    memCtrlE.loadByte   = byteAccessE;
    memCtrlE.byteOffset = aluResultE[1:0];  // Lane for byte extraction
  end

  // ======================================
  // Memory
  // ======================================
  always_ff @(posedge clk) begin
    if (reset)
      memCtrlM <= '0;
    else if (!stallM)
      memCtrlM <= memCtrlE;   // No flush on this stage
  end

  always_comb begin
    wbCtrlM.memToReg   = memCtrlM.memToReg;
    wbCtrlM.regWrite   = memCtrlM.regWrite;
    wbCtrlM.pcSrc      = memCtrlM.pcSrc;
    wbCtrlM.loadByte   = memCtrlM.loadByte;
    wbCtrlM.byteOffset = memCtrlM.byteOffset;
  end

  // ======================================
  // Writeback
  // ======================================
  always_ff @(posedge clk) begin
    if (reset || flushW)
      wbCtrlW <= '0;
    else if (!stallW)
      wbCtrlW <= wbCtrlM;
  end

  // Any PC write in flight holds off fetch
  assign pcWrPendingF = ctrlD.pcSrc | ctrlE.pcSrc | memCtrlM.pcSrc;

endmodule

`default_nettype wire

// ==== logic/mainDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "armCtrl_cfg.svh"

module mainDecoder import armCtrlPkg::*; (
  input  instrWordT  instr,
  output decodeCtrlT ctrl
);

  logic [`CW_WIDTH-1:0] cw;   // Per-class control word
  logic [1:0]           instrClass;
  logic                 isMult;

  assign instrClass = instr.dpView.instrClass;
  assign isMult     = (instr.dpView.rest[7:4] == 4'b1001);  // MUL/MLA signature

  // ======================================
  // Class table
  // ======================================
  // Bit order: aluSrc memToReg regWrite memWrite branch aluOp multSel memAluOp
  always_comb begin
    case (instrClass)
      `CLASS_DP: begin
        if (instr.dpView.immFlag)
          cw = 8'b1010_0100;         // DP immediate
        else if (isMult)
          cw = 8'b0010_0110;         // Multiply
        else
          cw = 8'b0010_0100;         // DP register
      end
      `CLASS_MEM: begin
        case ({instr.memView.load, instr.memView.regOffset})
          2'b10:   cw = 8'b1110_0001;  // LDR I-type
          2'b11:   cw = 8'b0110_0001;  // LDR R-type
          2'b00:   cw = 8'b1001_0001;  // STR I-type
          default: cw = 8'b0001_0001;  // STR R-type
        endcase
      end
      `CLASS_BR: cw = 8'b1000_1000;    // B, immediate target
      default:   cw = '0;              // Unimplemented, no side effects
    endcase
  end

  // ======================================
  // Bundle assembly
  // ======================================
  always_comb begin
    ctrl             = '0;
    ctrl.aluSrc      = cw[`CW_ALUSRC];
    ctrl.memToReg    = cw[`CW_MEMTOREG];
    ctrl.regWrite    = cw[`CW_REGWRITE];
    ctrl.memWrite    = cw[`CW_MEMWRITE];
    ctrl.branch      = cw[`CW_BRANCH];
    ctrl.aluOp       = cw[`CW_ALUOP];
    ctrl.multSelect  = cw[`CW_MULTSEL];
    ctrl.memAluOp    = cw[`CW_MEMALUOP];
    ctrl.multControl = instr.dpView.opcode[2:0];  // Bits 23:21
    ctrl.cond        = instr.dpView.cond;

    if (cw[`CW_ALUOP]) begin
      ctrl.aluControl = instr.dpView.opcode;
      ctrl.flagWrite  = {2{instr.dpView.setFlags}};  // S bit sets both pairs
    end else if (instrClass == `CLASS_MEM) begin
      // U bit picks offset direction
      ctrl.aluControl = instr.memView.up ? `OP_ADD_MEM : `OP_SUB_MEM;
    end else begin
      ctrl.aluControl = `OP_ADD;  // Branch target add
    end

    // Writes to R15 redirect fetch like a branch
    ctrl.pcSrc = cw[`CW_BRANCH] |
                 (cw[`CW_REGWRITE] & (instr.dpView.rd == 4'd15));
  end

endmodule

`default_nettype wire

// ==== logic/condUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "armCtrl_cfg.svh"

module condUnit import armCtrlPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       stallE,
  input  logic [3:0] cond,
  input  logic [1:0] flagWrite,   // {NZ, CV}
  input  flagsT      aluFlags,
  output logic       condEx,
  output flagsT      flags        // Stored flag register
);

  flagsT flagsNext;
  logic  nEqV;                    // Signed greater-or-equal

  assign nEqV = ~(flags.n ^ flags.v);

  // ======================================
  // Condition check
  // ======================================
  always_comb begin
    case (cond)
      `COND_EQ: condEx = flags.z;
      `COND_NE: condEx = ~flags.z;
      `COND_CS: condEx = flags.c;
      `COND_CC: condEx = ~flags.c;
      `COND_MI: condEx = flags.n;
      `COND_PL: condEx = ~flags.n;
      `COND_VS: condEx = flags.v;
      `COND_VC: condEx = ~flags.v;
      `COND_HI: condEx = flags.c & ~flags.z;     // Unsigned higher
      `COND_LS: condEx = ~flags.c | flags.z;
      `COND_GE: condEx = nEqV;
      `COND_LT: condEx = ~nEqV;
      `COND_GT: condEx = ~flags.z & nEqV;
      `COND_LE: condEx = flags.z | ~nEqV;
      `COND_AL: condEx = 1'b1;
      default:  condEx = 1'b0;                   // NV space never executes
    endcase
  end

  // ======================================
  // Flag register
  // ======================================
  // Each pair updates only when the instruction itself passes
  always_comb begin
    flagsNext = flags;
    if (flagWrite[1] & condEx) begin
      flagsNext.n = aluFlags.n;
      flagsNext.z = aluFlags.z;
    end
    if (flagWrite[0] & condEx) begin
      flagsNext.c = aluFlags.c;
      flagsNext.v = aluFlags.v;
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      flags <= '0;
    else if (!stallE)
      flags <= flagsNext;  // Same enable as the Execute register
  end

endmodule

`default_nettype wire

// ==== logic/aluDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "armCtrl_cfg.svh"

module aluDecoder import armCtrlPkg::*; (
  input  logic       aluOp,
  input  logic [3:0] aluControl,
  input  logic       carry,       // Stored C flag
  output aluSteerT   steer
);

  always_comb begin
    steer = '0;  // Plain add, carry-in 0, flags untouched
    if (aluOp) begin
      case (aluControl)
        `OP_AND: begin
          steer.operation = `ALU_AND;
          steer.cvUpdate  = `CV_LOGIC;
        end
        `OP_EOR: begin
          steer.operation = `ALU_XOR;
          steer.cvUpdate  = `CV_LOGIC;
        end
        `OP_SUB: begin
          steer.cvUpdate = `CV_ARITH;
          steer.invertB  = 1'b1;
          steer.carryIn  = 1'b1;      // A + ~B + 1
        end
        `OP_RSB: begin
          steer.cvUpdate      = `CV_ARITH;
          steer.reverseInputs = 1'b1;
          steer.carryIn       = 1'b1;
        end
        `OP_ADD: steer.cvUpdate = `CV_ARITH;
        `OP_ADC: begin
          steer.cvUpdate = `CV_ARITH;
          steer.carryIn  = carry;
        end
        `OP_SBC: begin
          steer.cvUpdate = `CV_ARITH;
          steer.invertB  = 1'b1;
          steer.carryIn  = carry;     // Borrow is ~C
        end
        `OP_RSC: begin
          steer.cvUpdate      = `CV_ARITH;
          steer.reverseInputs = 1'b1;
          steer.carryIn       = carry;
        end
        `OP_TST: begin
          steer.operation  = `ALU_AND;
          steer.cvUpdate   = `CV_LOGIC;
          steer.noRegWrite = 1'b1;
        end
        `OP_TEQ: begin
          steer.operation  = `ALU_XOR;
          steer.cvUpdate   = `CV_LOGIC;
          steer.noRegWrite = 1'b1;
        end
        `OP_CMP: begin
          steer.cvUpdate   = `CV_ARITH;
          steer.invertB    = 1'b1;
          steer.carryIn    = 1'b1;
          steer.noRegWrite = 1'b1;
        end
        `OP_CMN: begin
          steer.cvUpdate   = `CV_ARITH;
          steer.noRegWrite = 1'b1;
        end
        `OP_ORR: begin
          steer.operation = `ALU_OR;
          steer.cvUpdate  = `CV_LOGIC;
        end
        `OP_MOV: begin
          steer.operation = `ALU_PASS;
          steer.cvUpdate  = `CV_LOGIC;
        end
        `OP_BIC: begin
          steer.operation = `ALU_AND;   // A & ~B
          steer.cvUpdate  = `CV_LOGIC;
          steer.invertB   = 1'b1;
        end
        `OP_MVN: begin
          steer.operation = `ALU_PASS;  // Passes ~B
          steer.cvUpdate  = `CV_LOGIC;
          steer.invertB   = 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/armCtrlPkg.sv ====
`default_nettype none

package armCtrlPkg;

  // Data-processing view of one instruction word
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  instrClass;    // Bits 27:26
    logic        immFlag;       // I bit, operand 2 is immediate
    logic [3:0]  opcode;        // Bits 24:21
    logic        setFlags;      // S bit
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] rest;          // Operand 2, multiply pattern in 7:4
  } dpFieldsT;

  // Single data transfer view of the same word
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  instrClass;
    logic        regOffset;     // Register offset when set
    logic        pre;           // Pre-index
    logic        up;            // Add offset when set
    logic        byteAccess;    // B bit
    logic        writeBack;
    logic        load;          // L bit
    logic [3:0]  rn;            // Base
    logic [3:0]  rd;            // Data register
    logic [11:0] offset;
  } memFieldsT;

  // Decoder picks the view from the class bits
  typedef union packed {
    dpFieldsT  dpView;
    memFieldsT memView;
  } instrWordT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // Decode to Execute
  typedef struct packed {
    logic       aluSrc;
    logic       memToReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       aluOp;          // Data processing, opcode drives ALU
    logic       multSelect;
    logic       pcSrc;
    logic       memAluOp;       // Load/store address add or subtract
    logic [1:0] flagWrite;      // {NZ, CV}
    logic [3:0] aluControl;
    logic [2:0] multControl;
    logic [3:0] cond;
  } decodeCtrlT;

  // Execute to Memory, write controls already gated
  typedef struct packed {
    logic       memWrite;
    logic       memToReg;
    logic       regWrite;
    logic       pcSrc;
    logic [3:0] byteMask;
    logic       loadByte;
    logic [1:0] byteOffset;
  } memCtrlT;

  // Memory to Writeback
  typedef struct packed {
    logic       memToReg;
    logic       regWrite;
    logic       pcSrc;
    logic       loadByte;
    logic [1:0] byteOffset;
  } wbCtrlT;

  typedef struct packed {
    logic [2:0] operation;      // Add, and, or, xor, pass
    logic [2:0] cvUpdate;       // {update C, update V, C from shifter}
    logic       invertB;
    logic       reverseInputs;
    logic       carryIn;
    logic       noRegWrite;     // Compare and test forms
  } aluSteerT;

endpackage

`default_nettype wire

// ==== logic/armCtrl_cfg.svh ====
`ifndef ARMCTRL_CFG_SVH
`define ARMCTRL_CFG_SVH

// ======================================
// Data-processing opcodes
// ======================================
`define OP_AND     4'b0000
`define OP_EOR     4'b0001
`define OP_SUB     4'b0010
`define OP_RSB     4'b0011
`define OP_ADD     4'b0100
`define OP_ADC     4'b0101
`define OP_SBC     4'b0110
`define OP_RSC     4'b0111
`define OP_TST     4'b1000
`define OP_TEQ     4'b1001
`define OP_CMP     4'b1010
`define OP_CMN     4'b1011
`define OP_ORR     4'b1100
`define OP_MOV     4'b1101
`define OP_BIC     4'b1110
`define OP_MVN     4'b1111
`define OP_ADD_MEM 4'b0100  // Address = base + offset
`define OP_SUB_MEM 4'b0010  // Address = base - offset

// ======================================
// Condition codes
// ======================================
`define COND_EQ 4'b0000
`define COND_NE 4'b0001
`define COND_CS 4'b0010
`define COND_CC 4'b0011
`define COND_MI 4'b0100
`define COND_PL 4'b0101
`define COND_VS 4'b0110
`define COND_VC 4'b0111
`define COND_HI 4'b1000
`define COND_LS 4'b1001
`define COND_GE 4'b1010
`define COND_LT 4'b1011
`define COND_GT 4'b1100
`define COND_LE 4'b1101
`define COND_AL 4'b1110

// Instruction classes, bits 27:26
`define CLASS_DP  2'b00
`define CLASS_MEM 2'b01
`define CLASS_BR  2'b10

// Main decoder control word bit positions
`define CW_WIDTH    8
`define CW_ALUSRC   7
`define CW_MEMTOREG 6
`define CW_REGWRITE 5
`define CW_MEMWRITE 4
`define CW_BRANCH   3
`define CW_ALUOP    2
`define CW_MULTSEL  1
`define CW_MEMALUOP 0

// ALU steering encodings
`define ALU_ADD  3'b000
`define ALU_AND  3'b001
`define ALU_OR   3'b010
`define ALU_XOR  3'b011
`define ALU_PASS 3'b100
`define CV_NONE  3'b000
`define CV_ARITH 3'b110   // C and V from adder
`define CV_LOGIC 3'b001   // C from shifter, V kept

`endif
